//--- logic/alu_unit.sv
/*
 * ALU
 * Add, sub, and, or and both shifts, plus compare flags
 */
module alu_unit (
    input  cpu_pkg::word_t    a,
    input  cpu_pkg::word_t    b,
    input  cpu_pkg::alu_op_t  op,
    input  cpu_pkg::reg_idx_t shamt,
    output cpu_pkg::word_t    result,
    output logic              not_equal,
    output logic              less_than
);

    // --------------------
    // Function select
    always_comb begin
        case (op)
            cpu_pkg::ALU_ADD: result = a + b;
            cpu_pkg::ALU_SUB: result = a - b;
            cpu_pkg::ALU_AND: result = a & b;
            cpu_pkg::ALU_OR:  result = a | b;
            cpu_pkg::ALU_SLL: result = a << shamt;              // Shifts use a only
            cpu_pkg::ALU_SRA: result = $signed(a) >>> shamt;    // Keeps sign
            default:          result = '0;
        endcase
    end

    // --------------------
    // Flags for branches, independent of op
    assign not_equal = (a != b);
    assign less_than = ($signed(a) < $signed(b));   // Signed a < b

endmodule

//--- logic/branch_unit.sv
/*
 * Branch unit
 * Taken decision for bne and blt, and the PC-relative target
 */
module branch_unit (
    input  logic           is_bne,
    input  logic           is_blt,
    input  logic           not_equal,   // From ALU, a != b
    input  logic           less_than,   // From ALU, rd < rs
    input  cpu_pkg::word_t pc_plus1,
    input  cpu_pkg::word_t imm,
    output logic           taken,
    output cpu_pkg::word_t target
);

    // Predicted not taken, so taken means mispredict
    assign taken = (is_bne && not_equal) || (is_blt && less_than);

    // Offset counts from the next instruction
    assign target = pc_plus1 + imm;

endmodule

//--- logic/cpu_pkg.sv
/*
 * CPU package
 * Word and register types, opcodes, ALU codes and instruction field positions
 * shared by all pipeline stages
 */
package cpu_pkg;

    // --------------------
    // Basic types
    typedef logic [31:0] word_t;    // Data or address word
    typedef logic [4:0]  reg_idx_t; // Register number

    // --------------------
    // Opcodes, bits [31:27]
    typedef enum logic [4:0] {
        OP_RTYPE = 5'd0,  // ALU op from aluop field
        OP_J     = 5'd1,  // Resolved in fetch
        OP_BNE   = 5'd2,
        OP_ADDI  = 5'd5,
        OP_BLT   = 5'd6,
        OP_SW    = 5'd7,
        OP_LW    = 5'd8
    } opcode_t;

    // ALU function codes, same encoding as the R-type aluop field
    typedef enum logic [4:0] {
        ALU_ADD = 5'd0,
        ALU_SUB = 5'd1,
        ALU_AND = 5'd2,
        ALU_OR  = 5'd3,
        ALU_SLL = 5'd4,
        ALU_SRA = 5'd5
    } alu_op_t;

    // --------------------
    // Field positions, MSB of each 5-bit field
    localparam int OPCODE_MSB = 31;
    localparam int RD_MSB     = 26;
    localparam int RS_MSB     = 21;
    localparam int RT_MSB     = 16;
    localparam int SHAMT_MSB  = 11;
    localparam int ALUOP_MSB  = 6;

    // Widths of the low-aligned immediate fields
    localparam int IMM_W      = 17; // I-type immediate
    localparam int TARGET_W   = 27; // J-type target

    // First fetch address after reset
    localparam word_t RESET_PC = 32'd0;

endpackage

//--- logic/decode_stage.sv
/*
 * Decode stage
 * Field split, control generation, register read selection and the DX latch
 */
module decode_stage (
    input  logic              clock,
    input  logic              arst_n,
    input  cpu_pkg::word_t    ir_fd,
    input  cpu_pkg::word_t    pc_plus1_fd,
    input  logic              redirect,         // Load a bubble into DX
    input  cpu_pkg::word_t    data_read_reg_a,
    input  cpu_pkg::word_t    data_read_reg_b,
    output cpu_pkg::reg_idx_t ctrl_read_reg_a,
    output cpu_pkg::reg_idx_t ctrl_read_reg_b,
    dx_if.src                 dx
);

    localparam int WORD_W = $bits(cpu_pkg::word_t);
    localparam int IDX_W  = $bits(cpu_pkg::reg_idx_t);

    cpu_pkg::opcode_t  opcode;
    cpu_pkg::reg_idx_t rd, rs, rt;
    cpu_pkg::alu_op_t  alu_op;
    cpu_pkg::word_t    imm_ext;
    logic use_imm, reg_we, mem_we, mem_to_reg, is_bne, is_blt;

    // --------------------
    // Field split
    assign opcode = cpu_pkg::opcode_t'(ir_fd[cpu_pkg::OPCODE_MSB -: IDX_W]);
    assign rd     = ir_fd[cpu_pkg::RD_MSB -: IDX_W];
    assign rs     = ir_fd[cpu_pkg::RS_MSB -: IDX_W];
    assign rt     = ir_fd[cpu_pkg::RT_MSB -: IDX_W];

    assign imm_ext = {{(WORD_W - cpu_pkg::IMM_W){ir_fd[cpu_pkg::IMM_W-1]}},
                      ir_fd[cpu_pkg::IMM_W-1:0]};

    // --------------------
    // Control per opcode, j and unknown codes do nothing here
    always_comb begin
        alu_op     = cpu_pkg::ALU_ADD;
        use_imm    = 1'b0;
        reg_we     = 1'b0;
        mem_we     = 1'b0;
        mem_to_reg = 1'b0;
        is_bne     = 1'b0;
        is_blt     = 1'b0;
        case (opcode)
            cpu_pkg::OP_RTYPE: begin
                alu_op = cpu_pkg::alu_op_t'(ir_fd[cpu_pkg::ALUOP_MSB -: IDX_W]);
                reg_we = 1'b1;
            end
            cpu_pkg::OP_ADDI: begin
                use_imm = 1'b1;
                reg_we  = 1'b1;
            end
            cpu_pkg::OP_LW: begin
                use_imm    = 1'b1;  // Address is rs + imm
                reg_we     = 1'b1;
                mem_to_reg = 1'b1;
            end
            cpu_pkg::OP_SW: begin
                use_imm = 1'b1;
                mem_we  = 1'b1;
            end
            cpu_pkg::OP_BNE: is_bne = 1'b1;  // Compare on flags only
            cpu_pkg::OP_BLT: is_blt = 1'b1;
            default: ;
        endcase
    end

    // Branches compare rd against rs, sw stores rd
    assign ctrl_read_reg_a = (is_bne || is_blt) ? rd : rs;
    assign ctrl_read_reg_b = (is_bne || is_blt) ? rs : (mem_we ? rd : rt);

    // --------------------
    // DX latch, control
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            dx.use_imm    <= 1'b0;
            dx.reg_we     <= 1'b0;
            dx.mem_we     <= 1'b0;
            dx.mem_to_reg <= 1'b0;
            dx.is_bne     <= 1'b0;
            dx.is_blt     <= 1'b0;
        end else begin
            dx.use_imm    <= use_imm;
            dx.reg_we     <= reg_we && (rd != '0) && !redirect;  // r0 is never written
            dx.mem_we     <= mem_we && !redirect;
            dx.mem_to_reg <= mem_to_reg;
            dx.is_bne     <= is_bne && !redirect;
            dx.is_blt     <= is_blt && !redirect;
        end
    end

    // DX latch, payload
    always_ff @(posedge clock) begin
        dx.pc_plus1 <= pc_plus1_fd;
        dx.a        <= data_read_reg_a;
        dx.b        <= data_read_reg_b;
        dx.imm      <= imm_ext;
        dx.rd       <= rd;
        dx.shamt    <= ir_fd[cpu_pkg::SHAMT_MSB -: IDX_W];
        dx.alu_op   <= alu_op;
    end

endmodule

//--- logic/dx_if.sv
/*
 * Decode to execute bus
 * Registered operands and control of one instruction sitting in DX
 */
interface dx_if;

    // --------------------
    // Payload
    cpu_pkg::word_t    pc_plus1;  // Branch base address
    cpu_pkg::word_t    a;         // Register port A value
    cpu_pkg::word_t    b;         // Register port B value
    cpu_pkg::word_t    imm;       // Sign extended immediate
    cpu_pkg::reg_idx_t rd;        // Destination register
    cpu_pkg::reg_idx_t shamt;     // Shift amount
    cpu_pkg::alu_op_t  alu_op;    // ALU function

    // --------------------
    // Control, all zero in a bubble
    logic use_imm;     // ALU B takes imm
    logic reg_we;      // Writes rd at writeback
    logic mem_we;      // Store
    logic mem_to_reg;  // Load result to rd
    logic is_bne;
    logic is_blt;

    // Decode side owns the DX registers
    modport src (
        output pc_plus1, a, b, imm, rd, shamt, alu_op,
        output use_imm, reg_we, mem_we, mem_to_reg, is_bne, is_blt
    );

    // Execute side only reads
    modport dst (
        input pc_plus1, a, b, imm, rd, shamt, alu_op,
        input use_imm, reg_we, mem_we, mem_to_reg, is_bne, is_blt
    );

endinterface

//--- logic/execute_stage.sv
/*
 * Execute stage
 * ALU and branch resolution side by side, the XM latch and the fetch redirect
 */
module execute_stage (
    input  logic              clock,
    input  logic              arst_n,
    dx_if.dst                 dx,
    output logic              redirect,       // Taken branch, squash FD and DX
    output cpu_pkg::word_t    redirect_pc,
    output cpu_pkg::word_t    alu_result_xm,
    output cpu_pkg::word_t    store_data_xm,
    output cpu_pkg::reg_idx_t rd_xm,
    output logic              reg_we_xm,
    output logic              mem_we_xm,
    output logic              mem_to_reg_xm
);

    cpu_pkg::word_t alu_b;
    cpu_pkg::word_t alu_result;
    logic           not_equal;
    logic           less_than;

    // Second operand, imm for addi, lw and sw
    assign alu_b = dx.use_imm ? dx.imm : dx.b;

    alu_unit u_alu (
        .a         (dx.a),
        .b         (alu_b),
        .op        (dx.alu_op),
        .shamt     (dx.shamt),
        .result    (alu_result),
        .not_equal (not_equal),
        .less_than (less_than)
    );

    // --------------------
    // Branch resolution
    branch_unit u_branch (
        .is_bne    (dx.is_bne),
        .is_blt    (dx.is_blt),
        .not_equal (not_equal),
        .less_than (less_than),
        .pc_plus1  (dx.pc_plus1),
        .imm       (dx.imm),
        .taken     (redirect),
        .target    (redirect_pc)
    );

    // --------------------
    // XM latch, control
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            reg_we_xm     <= 1'b0;
            mem_we_xm     <= 1'b0;
            mem_to_reg_xm <= 1'b0;
        end else begin
            reg_we_xm     <= dx.reg_we;
            mem_we_xm     <= dx.mem_we;
            mem_to_reg_xm <= dx.mem_to_reg;
        end
    end

    // XM latch, payload
    always_ff @(posedge clock) begin
        alu_result_xm <= alu_result;    // Result or memory address
        store_data_xm <= dx.b;          // rd value for sw
        rd_xm         <= dx.rd;
    end

endmodule

//--- logic/fetch_stage.sv
/*
 * Fetch stage
 * PC register with early j handling, branch redirect and the FD latch
 */
module fetch_stage (
    input  logic           clock,
    input  logic           arst_n,
    input  cpu_pkg::word_t q_imem,       // Instruction at address_imem
    input  logic           redirect,     // Taken branch in execute
    input  cpu_pkg::word_t redirect_pc,
    output cpu_pkg::word_t address_imem,
    output cpu_pkg::word_t ir_fd,
    output cpu_pkg::word_t pc_plus1_fd
);

    localparam int WORD_W = $bits(cpu_pkg::word_t);

    cpu_pkg::word_t pc;
    cpu_pkg::word_t pc_plus1;
    cpu_pkg::word_t jump_target;
    cpu_pkg::word_t next_pc;
    logic           is_j;

    assign address_imem = pc;
    assign pc_plus1     = pc + cpu_pkg::word_t'(1);

    // --------------------
    // Early jump decode, straight off the imem data
    assign is_j = (q_imem[cpu_pkg::OPCODE_MSB -: 5] == cpu_pkg::OP_J);

    // Target is sign extended, absolute
    assign jump_target = {{(WORD_W - cpu_pkg::TARGET_W){q_imem[cpu_pkg::TARGET_W-1]}},
                          q_imem[cpu_pkg::TARGET_W-1:0]};

    // Redirect wins, a j in this slot is on the wrong path then
    always_comb begin
        if (redirect)  next_pc = redirect_pc;
        else if (is_j) next_pc = jump_target;
        else           next_pc = pc_plus1;
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            pc <= cpu_pkg::RESET_PC;
        end else begin
            pc <= next_pc;
        end
    end

    // --------------------
    // FD latch
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            ir_fd <= '0;                            // Nop
        end else begin
            ir_fd <= redirect ? '0 : q_imem;        // Squash the younger slot
        end
    end

    // PC+1 is payload only
    always_ff @(posedge clock) begin
        pc_plus1_fd <= pc_plus1;
    end

endmodule

//--- logic/mem_wb_stage.sv
/*
 * Memory and writeback stages
 * Data memory drive from XM, the MW latch and the writeback select
 */
module mem_wb_stage (
    input  logic              clock,
    input  logic              arst_n,
    input  cpu_pkg::word_t    alu_result_xm,
    input  cpu_pkg::word_t    store_data_xm,
    input  cpu_pkg::reg_idx_t rd_xm,
    input  logic              reg_we_xm,
    input  logic              mem_we_xm,
    input  logic              mem_to_reg_xm,
    input  cpu_pkg::word_t    q_dmem,             // Load data, same cycle
    output cpu_pkg::word_t    address_dmem,
    output cpu_pkg::word_t    data,
    output logic              wren,
    output logic              ctrl_write_enable,
    output cpu_pkg::reg_idx_t ctrl_write_reg,
    output cpu_pkg::word_t    data_write_reg
);

    cpu_pkg::word_t result_mw;
    cpu_pkg::word_t load_mw;
    logic           mem_to_reg_mw;

    // --------------------
    // Memory access, straight from XM
    assign address_dmem = alu_result_xm;
    assign data         = store_data_xm;
    assign wren         = mem_we_xm;

    // --------------------
    // MW latch
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            ctrl_write_enable <= 1'b0;
            mem_to_reg_mw     <= 1'b0;
        end else begin
            ctrl_write_enable <= reg_we_xm;
            mem_to_reg_mw     <= mem_to_reg_xm;
        end
    end

    always_ff @(posedge clock) begin
        result_mw      <= alu_result_xm;
        load_mw        <= q_dmem;
        ctrl_write_reg <= rd_xm;
    end

    // Writeback select, loaded word for lw
    assign data_write_reg = mem_to_reg_mw ? load_mw : result_mw;

endmodule

//--- logic/processor.sv
/*
 * Processor top
 * Five-stage pipeline wired to external imem, dmem and register file ports
 */
module processor (
    input  logic              clock,
    input  logic              arst_n,
    // Imem
    output cpu_pkg::word_t    address_imem,
    input  cpu_pkg::word_t    q_imem,
    // Dmem
    output cpu_pkg::word_t    address_dmem,
    output cpu_pkg::word_t    data,
    output logic              wren,
    input  cpu_pkg::word_t    q_dmem,
    // Register file
    output logic              ctrl_write_enable,
    output cpu_pkg::reg_idx_t ctrl_write_reg,
    output cpu_pkg::reg_idx_t ctrl_read_reg_a,
    output cpu_pkg::reg_idx_t ctrl_read_reg_b,
    output cpu_pkg::word_t    data_write_reg,
    input  cpu_pkg::word_t    data_read_reg_a,
    input  cpu_pkg::word_t    data_read_reg_b
);

    cpu_pkg::word_t    ir_fd, pc_plus1_fd;
    logic              redirect;
    cpu_pkg::word_t    redirect_pc;
    cpu_pkg::word_t    alu_result_xm, store_data_xm;
    cpu_pkg::reg_idx_t rd_xm;
    logic              reg_we_xm, mem_we_xm, mem_to_reg_xm;

    dx_if dx_bus ();    // DX registers

    fetch_stage u_fetch (
        .clock        (clock),
        .arst_n       (arst_n),
        .q_imem       (q_imem),
        .redirect     (redirect),
        .redirect_pc  (redirect_pc),
        .address_imem (address_imem),
        .ir_fd        (ir_fd),
        .pc_plus1_fd  (pc_plus1_fd)
    );

    decode_stage u_decode (
        .clock           (clock),
        .arst_n          (arst_n),
        .ir_fd           (ir_fd),
        .pc_plus1_fd     (pc_plus1_fd),
        .redirect        (redirect),
        .data_read_reg_a (data_read_reg_a),
        .data_read_reg_b (data_read_reg_b),
        .ctrl_read_reg_a (ctrl_read_reg_a),
        .ctrl_read_reg_b (ctrl_read_reg_b),
        .dx              (dx_bus)
    );

    execute_stage u_execute (
        .clock         (clock),
        .arst_n        (arst_n),
        .dx            (dx_bus),
        .redirect      (redirect),
        .redirect_pc   (redirect_pc),
        .alu_result_xm (alu_result_xm),
        .store_data_xm (store_data_xm),
        .rd_xm         (rd_xm),
        .reg_we_xm     (reg_we_xm),
        .mem_we_xm     (mem_we_xm),
        .mem_to_reg_xm (mem_to_reg_xm)
    );

    mem_wb_stage u_mem_wb (
        .clock             (clock),
        .arst_n            (arst_n),
        .alu_result_xm     (alu_result_xm),
        .store_data_xm     (store_data_xm),
        .rd_xm             (rd_xm),
        .reg_we_xm         (reg_we_xm),
        .mem_we_xm         (mem_we_xm),
        .mem_to_reg_xm     (mem_to_reg_xm),
        .q_dmem            (q_dmem),
        .address_dmem      (address_dmem),
        .data              (data),
        .wren              (wren),
        .ctrl_write_enable (ctrl_write_enable),
        .ctrl_write_reg    (ctrl_write_reg),
        .data_write_reg    (data_write_reg)
    );

endmodule

//--- run.sh
#!/bin/sh
# Build and run the processor testbench with Verilator, verdict from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert --timescale 1ns/1ps --top-module tb_processor -f sources.f \
    > sim.log 2>&1 && ./obj_dir/Vtb_processor >> sim.log 2>&1
cat sim.log
grep -q "ERRORS FOUND" sim.log && exit 1
grep -q "NO ERRORS" sim.log || exit 1
exit 0

//--- sources.f
logic/cpu_pkg.sv
logic/dx_if.sv
logic/alu_unit.sv
logic/branch_unit.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/mem_wb_stage.sv
logic/processor.sv
tb/tb_processor.sv

//--- tb/tb_processor.sv
/*
 * Processor testbench
 * Memory and register-file models, a fixed program with LCG operands,
 * an ISA reference model and assertions on the write and store streams
 */
module tb_processor;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int IMEM_DEPTH    = 256;
    localparam int DMEM_DEPTH    = 64;
    localparam int RESET_CYCLES  = 2;
    localparam int SETTLE_CYCLES = 6;     // Cycles watched on the final self loop
    localparam int MODEL_STEPS   = 1000;  // Guard for the ISA model loop

    // --------------------
    // DUT ports
    logic              clock;
    logic              arst_n;
    cpu_pkg::word_t    address_imem, q_imem;
    cpu_pkg::word_t    address_dmem, data, q_dmem;
    logic              wren;
    logic              ctrl_write_enable;
    cpu_pkg::reg_idx_t ctrl_write_reg, ctrl_read_reg_a, ctrl_read_reg_b;
    cpu_pkg::word_t    data_write_reg, data_read_reg_a, data_read_reg_b;

    // --------------------
    // Models and bookkeeping
    cpu_pkg::word_t    imem [IMEM_DEPTH];
    cpu_pkg::word_t    dmem [DMEM_DEPTH];
    cpu_pkg::word_t    rf   [32];
    cpu_pkg::word_t    mregs [32];          // ISA model registers
    cpu_pkg::word_t    mdmem [DMEM_DEPTH];  // ISA model data memory
    cpu_pkg::reg_idx_t exp_wr_reg [$];
    cpu_pkg::word_t    exp_wr_data [$];
    cpu_pkg::word_t    exp_st_addr [$];
    cpu_pkg::word_t    exp_st_data [$];
    cpu_pkg::reg_idx_t wr_reg_exp;
    cpu_pkg::word_t    wr_data_exp, st_addr_exp, st_data_exp;
    cpu_pkg::word_t    lcg_state = 32'd67;
    cpu_pkg::word_t    end_pc;              // Address of the final self jump
    int                prog_len = 0;
    int                cycle_count = 0;
    int                timeout_limit = 0;
    logic              model_done = 1'b0;
    logic              settled;             // Pipeline drained, PC must sit on end_pc

    processor dut (
        .clock             (clock),
        .arst_n            (arst_n),
        .address_imem      (address_imem),
        .q_imem            (q_imem),
        .address_dmem      (address_dmem),
        .data              (data),
        .wren              (wren),
        .q_dmem            (q_dmem),
        .ctrl_write_enable (ctrl_write_enable),
        .ctrl_write_reg    (ctrl_write_reg),
        .ctrl_read_reg_a   (ctrl_read_reg_a),
        .ctrl_read_reg_b   (ctrl_read_reg_b),
        .data_write_reg    (data_write_reg),
        .data_read_reg_a   (data_read_reg_a),
        .data_read_reg_b   (data_read_reg_b)
    );

    always #5 clock = ~clock;   // 10 ns period

    // Memories answer in the same cycle, r0 reads as zero
    assign q_imem          = imem[address_imem[7:0]];
    assign q_dmem          = dmem[address_dmem[5:0]];
    assign data_read_reg_a = (ctrl_read_reg_a == '0) ? '0 : rf[ctrl_read_reg_a];
    assign data_read_reg_b = (ctrl_read_reg_b == '0) ? '0 : rf[ctrl_read_reg_b];

    // Writes land mid cycle, on the falling edge
    always @(negedge clock) begin
        if (ctrl_write_enable && ctrl_write_reg != '0) rf[ctrl_write_reg] = data_write_reg;
        if (wren) dmem[address_dmem[5:0]] = data;
    end

    // --------------------
    // Failure reporting
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string sig, input cpu_pkg::word_t got,
                                   input cpu_pkg::word_t exp);
        abort_run($sformatf("Fail at %0d ns: %s is %h, expected %h", $time, sig, got, exp));
    endtask

    // --------------------
    // Program construction
    function automatic cpu_pkg::word_t lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic cpu_pkg::word_t encode_rtype(logic [4:0] fn, logic [4:0] rd,
                                                    logic [4:0] rs, logic [4:0] rt,
                                                    logic [4:0] shamt);
        return {cpu_pkg::OP_RTYPE, rd, rs, rt, shamt, fn, 2'b00};
    endfunction

    function automatic cpu_pkg::word_t encode_itype(logic [4:0] op, logic [4:0] rd,
                                                    logic [4:0] rs, logic [16:0] imm);
        return {op, rd, rs, imm};
    endfunction

    function automatic cpu_pkg::word_t encode_jump(logic [26:0] target);
        return {cpu_pkg::OP_J, target};
    endfunction

    task automatic append_instr(input cpu_pkg::word_t instr);
        imem[prog_len] = instr;
        prog_len++;
    endtask

    task automatic add_gap(input int n);
        repeat (n) append_instr('0);   // Nops keep results three slots away
    endtask

    task automatic build_program();
        cpu_pkg::word_t rnd;
        rnd = lcg_next();
        append_instr(encode_itype(cpu_pkg::OP_ADDI, 1, 0, {1'b0, rnd[15:1], 1'b1})); // > 0
        rnd = lcg_next();
        append_instr(encode_itype(cpu_pkg::OP_ADDI, 2, 0, rnd[16:0]));
        rnd = lcg_next();
        append_instr(encode_itype(cpu_pkg::OP_ADDI, 3, 0, {1'b1, rnd[15:0]}));       // < 0
        append_instr(encode_itype(cpu_pkg::OP_ADDI, 4, 0, 17'd5));                   // Base
        add_gap(3);
        append_instr(encode_rtype(cpu_pkg::ALU_ADD, 5, 1, 2, 0));
        append_instr(encode_rtype(cpu_pkg::ALU_SUB, 6, 1, 2, 0));
        append_instr(encode_rtype(cpu_pkg::ALU_AND, 7, 1, 2, 0));
        append_instr(encode_rtype(cpu_pkg::ALU_OR,  8, 1, 2, 0));
        rnd = lcg_next();
        append_instr(encode_rtype(cpu_pkg::ALU_SLL, 9, 1, 0, rnd[4:0]));
        rnd = lcg_next();
        append_instr(encode_rtype(cpu_pkg::ALU_SRA, 10, 3, 0, rnd[4:0]));
        rnd = lcg_next();
        append_instr(encode_itype(cpu_pkg::OP_ADDI, 11, 2, {1'b1, rnd[15:0]}));      // Neg imm
        add_gap(3);
        // --------------------
        // Stores, then loads of the same words
        append_instr(encode_itype(cpu_pkg::OP_SW, 5, 0, 17'd3));
        append_instr(encode_itype(cpu_pkg::OP_SW, 6, 4, 17'd2));
        append_instr(encode_itype(cpu_pkg::OP_SW, 11, 4, 17'd0));
        append_instr(encode_itype(cpu_pkg::OP_LW, 12, 0, 17'd3));
        append_instr(encode_itype(cpu_pkg::OP_LW, 13, 0, 17'd7));
        append_instr(encode_itype(cpu_pkg::OP_LW, 14, 0, 17'd5));
        // --------------------
        // Branches, taken ones skip two writing slots
        append_instr(encode_itype(cpu_pkg::OP_BNE, 1, 0, 17'd2));    // Taken
        append_instr(encode_itype(cpu_pkg::OP_ADDI, 15, 0, 17'd1));
        append_instr(encode_itype(cpu_pkg::OP_ADDI, 16, 0, 17'd2));
        append_instr(encode_itype(cpu_pkg::OP_ADDI, 17, 0, 17'd3));
        append_instr(encode_itype(cpu_pkg::OP_BNE, 1, 1, 17'd2));    // Not taken
        append_instr(encode_itype(cpu_pkg::OP_ADDI, 18, 0, 17'd4));
        append_instr(encode_itype(cpu_pkg::OP_BLT, 3, 1, 17'd2));    // Taken, r3 < r1
        append_instr(encode_itype(cpu_pkg::OP_ADDI, 19, 0, 17'd5));
        append_instr(encode_itype(cpu_pkg::OP_ADDI, 20, 0, 17'd6));
        append_instr(encode_itype(cpu_pkg::OP_ADDI, 21, 0, 17'd7));
        append_instr(encode_itype(cpu_pkg::OP_BLT, 1, 3, 17'd2));    // Not taken
        append_instr(encode_itype(cpu_pkg::OP_ADDI, 22, 0, 17'd8));
        // Jump over two writing slots
        append_instr(encode_jump(27'(prog_len + 3)));
        append_instr(encode_itype(cpu_pkg::OP_ADDI, 23, 0, 17'd9));
        append_instr(encode_itype(cpu_pkg::OP_ADDI, 24, 0, 17'd10));
        append_instr(encode_itype(cpu_pkg::OP_ADDI, 25, 0, 17'd11));
        add_gap(3);
        append_instr(encode_jump(27'(prog_len)));                   // Self loop
    endtask

    // --------------------
    // ISA reference model, one instruction per step
    task automatic run_model();
        cpu_pkg::word_t pc, next_pc, ir, v_rs, v_rt, v_rd, imm, addr, result;
        logic [4:0]     op, rd, rs, rt, shamt, fn;
        int             steps;
        pc    = cpu_pkg::RESET_PC;
        steps = 0;
        for (int r = 0; r < 32; r++) mregs[r] = '0;
        for (int w = 0; w < DMEM_DEPTH; w++) mdmem[w] = dmem[w];
        while (!model_done && steps < MODEL_STEPS) begin
            ir      = imem[pc[7:0]];
            op      = ir[31:27];
            rd      = ir[26:22];
            rs      = ir[21:17];
            rt      = ir[16:12];
            shamt   = ir[11:7];
            fn      = ir[6:2];
            v_rs    = mregs[rs];
            v_rt    = mregs[rt];
            v_rd    = mregs[rd];
            imm     = {{15{ir[16]}}, ir[16:0]};
            next_pc = pc + 32'd1;
            result  = '0;
            case (op)
                cpu_pkg::OP_RTYPE: begin
                    case (fn)
                        cpu_pkg::ALU_ADD: result = v_rs + v_rt;
                        cpu_pkg::ALU_SUB: result = v_rs - v_rt;
                        cpu_pkg::ALU_AND: result = v_rs & v_rt;
                        cpu_pkg::ALU_OR:  result = v_rs | v_rt;
                        cpu_pkg::ALU_SLL: result = v_rs << shamt;
                        cpu_pkg::ALU_SRA: result = $signed(v_rs) >>> shamt;
                        default:          result = '0;
                    endcase
                    if (rd != '0) mregs[rd] = result;
                end
                cpu_pkg::OP_ADDI: if (rd != '0) mregs[rd] = v_rs + imm;
                cpu_pkg::OP_LW: begin
                    addr = v_rs + imm;
                    if (rd != '0) mregs[rd] = mdmem[addr[5:0]];
                end
                cpu_pkg::OP_SW: begin
                    addr = v_rs + imm;
                    mdmem[addr[5:0]] = v_rd;    // sw stores rd
                    exp_st_addr.push_back(addr);
                    exp_st_data.push_back(v_rd);
                end
                cpu_pkg::OP_BNE: if (v_rd != v_rs) next_pc = pc + 32'd1 + imm;
                cpu_pkg::OP_BLT: if ($signed(v_rd) < $signed(v_rs)) next_pc = pc + 32'd1 + imm;
                cpu_pkg::OP_J: begin
                    next_pc = {{5{ir[26]}}, ir[26:0]};
                    if (next_pc == pc) begin
                        end_pc     = pc;
                        model_done = 1'b1;
                    end
                end
                default: ;
            endcase
            // Record the write this instruction makes, r0 never counts
            if ((op == cpu_pkg::OP_RTYPE || op == cpu_pkg::OP_ADDI || op == cpu_pkg::OP_LW)
                && rd != '0) begin
                exp_wr_reg.push_back(rd);
                exp_wr_data.push_back(mregs[rd]);
            end
            pc = next_pc;
            steps++;
        end
    endtask

    // --------------------
    // Checkers, sampled on the rising edge
    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_limit)
            abort_run($sformatf("Timeout after %0d cycles, expected writes never drained",
                                cycle_count));
    end

    always @(posedge clock) begin
        if (!arst_n || cycle_count == RESET_CYCLES) begin   // In reset and first cycle out
            assert (!ctrl_write_enable && !wren && address_imem == cpu_pkg::RESET_PC) else begin
                if (ctrl_write_enable)
                    report_mismatch("ctrl_write_enable", cpu_pkg::word_t'(ctrl_write_enable), '0);
                else if (wren)
                    report_mismatch("wren", cpu_pkg::word_t'(wren), '0);
                else
                    report_mismatch("address_imem", address_imem, cpu_pkg::RESET_PC);
            end
        end
    end

    always @(posedge clock) begin
        if (arst_n && ctrl_write_enable) begin
            if (exp_wr_reg.size() == 0) begin
                abort_run("Register write after the last expected one");
            end else begin
                wr_reg_exp  = exp_wr_reg.pop_front();
                wr_data_exp = exp_wr_data.pop_front();
                assert (ctrl_write_reg == wr_reg_exp && data_write_reg == wr_data_exp) else begin
                    if (ctrl_write_reg != wr_reg_exp)
                        report_mismatch("ctrl_write_reg", cpu_pkg::word_t'(ctrl_write_reg),
                                        cpu_pkg::word_t'(wr_reg_exp));
                    else
                        report_mismatch("data_write_reg", data_write_reg, wr_data_exp);
                end
            end
        end
    end

    always @(posedge clock) begin
        if (arst_n && wren) begin
            if (exp_st_addr.size() == 0) begin
                abort_run("Store after the last expected one");
            end else begin
                st_addr_exp = exp_st_addr.pop_front();
                st_data_exp = exp_st_data.pop_front();
                assert (address_dmem == st_addr_exp && data == st_data_exp) else begin
                    if (address_dmem != st_addr_exp)
                        report_mismatch("address_dmem", address_dmem, st_addr_exp);
                    else
                        report_mismatch("data", data, st_data_exp);
                end
            end
        end
    end

    always @(posedge clock) begin
        if (settled) begin
            assert (address_imem == end_pc) else report_mismatch("address_imem", address_imem,
                                                                  end_pc);
        end
    end

    // --------------------
    // Main sequence
    initial begin
        int i;
        clock   = 1'b0;
        arst_n  = 1'b0;     // Reset from time 0
        settled = 1'b0;
        for (i = 0; i < 32; i++) rf[i] = '0;
        for (i = 0; i < IMEM_DEPTH; i++) imem[i] = '0;
        for (i = 0; i < DMEM_DEPTH; i++)
            dmem[i] = cpu_pkg::word_t'(i) * 32'h9E37_79B9 ^ 32'h5A5A_0000;
        build_program();
        run_model();
        timeout_limit = 4 * prog_len + 20;
        if (!model_done) begin
            abort_run("Reference model never reached the final self jump");
        end else begin
            repeat (RESET_CYCLES) @(posedge clock);
            @(negedge clock);
            arst_n = 1'b1;
            while (exp_wr_reg.size() != 0 || exp_st_addr.size() != 0) @(negedge clock);
            repeat (2) @(negedge clock);
            settled = 1'b1;
            repeat (SETTLE_CYCLES) @(negedge clock);  // Extra writes or PC drift would fire
            $display("NO ERRORS");
            $finish;
        end
    end

endmodule
